//--- bramDwc.sv
/*
 * Maps each 32-bit host word onto one lane of a 96-bit BRAM word.
 * BRAM word indices above the memory depth alias modulo the depth.
 */

`timescale 1ns/1ns

module bramDwc
  import bramDwcPkg::*;
(
  input  logic                   FromMaster_PS,
  input  logic                   rstN,
  input  logic                   bramEn,
  input  byteEnT                 bramWe,
  input  addrT                   bramAddr,
  input  mstWordT                bramWrData,
  output mstWordT                bramRdData,
  output logic                   memEn,
  output slvByteEnT              memWe,
  output logic [slvAddrBits-1:0] memAddr,
  output wideWordU               memWrData,
  input  wideWordU               memRdData
);

  // Address captured with the enable, keeps the read lane stable
  addrT addrQ;

  // Host word indices, live and registered
  logic [addrBits-3:0] mstWord;
  logic [addrBits-3:0] mstWordQ;

  // Lane of the current write and of the pending read
  logic [laneBits-1:0] wrLane;
  logic [laneBits-1:0] rdLane;

  always_ff @(posedge FromMaster_PS or negedge rstN) begin
    if (!rstN) begin
      addrQ <= '0;
    end else if (bramEn) begin
      addrQ <= bramAddr;
    end
  end

  assign mstWord  = bramAddr[addrBits-1:2];
  assign mstWordQ = addrQ[addrBits-1:2];

  // Three host words per BRAM word
  assign memAddr = slvAddrBits'(mstWord / laneCount);
  assign wrLane  = laneBits'(mstWord % laneCount);
  assign rdLane  = laneBits'(mstWordQ % laneCount);

  assign memEn = bramEn;

  // Same data on every lane, byte enables pick the lane
  always_comb begin
    for (int l = 0; l < laneCount; l++) begin
      memWrData.lane[l] = bramWrData;
    end
  end

  // Byte enables placed only in the addressed lane
  always_comb begin
    memWe = '0;
    for (int l = 0; l < laneCount; l++) begin
      if (wrLane == laneBits'(l)) begin
        memWe[l*mstBytes +: mstBytes] = bramWe;
      end
    end
  end

  // Read lane follows the address of the cycle that produced the data
  assign bramRdData = memRdData.lane[rdLane];

endmodule

//--- bramDwcPkg.sv
/*
 * Shared widths and types for the 32-bit host to 96-bit BRAM subsystem.
 * The BRAM word must hold exactly laneCount host words.
 */

package bramDwcPkg;

  // Host side
  localparam int addrBits    = 16;
  localparam int mstDataBits = 32;
  localparam int mstBytes    = mstDataBits / 8;

  // Memory side
  localparam int slvDataBits = 96;
  localparam int slvBytes    = slvDataBits / 8;
  localparam int slvDepth    = 256;
  localparam int slvAddrBits = $clog2(slvDepth);

  // Host words packed into one BRAM word
  localparam int laneCount = slvDataBits / mstDataBits;
  localparam int laneBits  = $clog2(laneCount + 1);

  // Register map, selected by addr[0] when regSel is high
  localparam int regBaseAddr = 0;
  localparam int regCtrlAddr = 1;

  // Host byte address
  typedef logic [addrBits-1:0] addrT;

  // Host data word
  typedef logic [mstDataBits-1:0] mstWordT;

  // Host byte enables
  typedef logic [mstBytes-1:0] byteEnT;

  // BRAM byte enables, lane 0 in the low bytes
  typedef logic [slvBytes-1:0] slvByteEnT;

  // Wide memory word
  // The memory stores it flat, the converter works per lane
  typedef union packed {
    logic [slvDataBits-1:0]      flat;
    mstWordT [laneCount-1:0]     lane;
  } wideWordU;

endpackage

//--- bramSubsysTop.sv
/*
 * Host req/ack port in front of a relocatable, write-protectable 96-bit BRAM.
 * One host, one outstanding request, no bursts.
 */

`timescale 1ns/1ns

module bramSubsysTop
  import bramDwcPkg::*;
(
  input  logic    FromMaster_PS,
  input  logic    rstN,
  input  logic    req,
  input  logic    we,
  input  logic    regSel,
  input  addrT    addr,
  input  mstWordT wrData,
  input  byteEnT  byteEn,
  output logic    ack,
  output mstWordT rdData
);

  // Controller to register block
  logic        regWrEn;
  logic        regAddrSel;
  mstWordT     regWrData;
  mstWordT     regRdData;
  logic [13:0] base;
  logic        protect;

  // Controller to converter, narrow BRAM port
  logic    bramEn;
  byteEnT  bramWe;
  addrT    bramAddr;
  mstWordT bramWrData;
  mstWordT bramRdData;

  // Converter to memory, wide BRAM port
  logic                   memEn;
  slvByteEnT              memWe;
  logic [slvAddrBits-1:0] memAddr;
  wideWordU               memWrData;
  wideWordU               memRdData;

  windowRegs uRegs (
    .FromMaster_PS, .rstN, .regWrEn, .regAddrSel, .regWrData, .regRdData,
    .base, .protect
  );

  hostPortCtrl uCtrl (
    .FromMaster_PS, .rstN, .req, .we, .regSel, .addr, .wrData, .byteEn,
    .ack, .rdData, .base, .protect, .regWrEn, .regAddrSel, .regWrData,
    .regRdData, .bramEn, .bramWe, .bramAddr, .bramWrData, .bramRdData
  );

  bramDwc uDwc (
    .FromMaster_PS, .rstN, .bramEn, .bramWe, .bramAddr, .bramWrData,
    .bramRdData, .memEn, .memWe, .memAddr, .memWrData, .memRdData
  );

  wideBram uMem (
    .FromMaster_PS, .rstN, .memEn, .memWe, .memAddr, .memWrData, .memRdData
  );

endmodule

//--- filelist.f
+incdir+.
bramDwcPkg.sv
windowRegs.sv
hostPortCtrl.sv
bramDwc.sv
wideBram.sv
bramSubsysTop.sv
tbBramSubsys.sv

//--- hostPortCtrl.sv
/*
 * Four-phase req/ack sequencer; host fields must stay stable while req is high.
 * Memory accesses ack three edges after req is sampled, register accesses two.
 */

`timescale 1ns/1ns

module hostPortCtrl
  import bramDwcPkg::*;
(
  input  logic        FromMaster_PS,
  input  logic        rstN,
  input  logic        req,
  input  logic        we,
  input  logic        regSel,
  input  addrT        addr,
  input  mstWordT     wrData,
  input  byteEnT      byteEn,
  output logic        ack,
  output mstWordT     rdData,
  input  logic [13:0] base,
  input  logic        protect,
  output logic        regWrEn,
  output logic        regAddrSel,
  output mstWordT     regWrData,
  input  mstWordT     regRdData,
  output logic        bramEn,
  output byteEnT      bramWe,
  output addrT        bramAddr,
  output mstWordT     bramWrData,
  input  mstWordT     bramRdData
);

  enum logic [2:0] {sIdle, sAccess, sWait, sAck, sRelease} state, stateNext;

  // Relocated host word index, wraps at 2^14 words
  logic [13:0] relocWord;

  assign relocWord = addr[addrBits-1:2] + base;

  always_ff @(posedge FromMaster_PS or negedge rstN) begin
    if (!rstN) begin
      state <= sIdle;
    end else begin
      state <= stateNext;
    end
  end

  // Register accesses skip the memory read wait
  always_comb begin
    stateNext = state;
    unique case (state)
      sIdle:    if (req) stateNext = sAccess;
      sAccess:  stateNext = regSel ? sAck : sWait;
      sWait:    stateNext = sAck;
      sAck:     stateNext = sRelease;
      sRelease: if (!req) stateNext = sIdle;
      default:  stateNext = sIdle;
    endcase
  end

  // One BRAM cycle per memory request
  assign bramEn     = (state == sAccess) && !regSel;
  // Protected writes still run the cycle but enable no bytes
  assign bramWe     = (bramEn && we && !protect) ? byteEn : '0;
  assign bramAddr   = {relocWord, 2'b00};
  assign bramWrData = wrData;

  // Register strobe, whole-word
  assign regWrEn    = (state == sAccess) && regSel && we;
  assign regAddrSel = addr[0];
  assign regWrData  = wrData;

  // Read data captured on the same edge that raises ack
  always_ff @(posedge FromMaster_PS or negedge rstN) begin
    if (!rstN) begin
      ack    <= 1'b0;
      rdData <= '0;
    end else if (state == sAck) begin
      ack <= 1'b1;
      if (!we) begin
        rdData <= regSel ? regRdData : bramRdData;
      end
    end else if ((state == sRelease) && !req) begin
      ack <= 1'b0;
    end
  end

  // Ack only answers a pending request
  ackNeedsReq: assert property (@(posedge FromMaster_PS) disable iff (!rstN)
    $rose(ack) |-> $past(req));

endmodule

//--- tbBramSubsysTasks.svh
/*
 * Host handshake and compare tasks, included inside the testbench module.
 * Every wait for ack gives up after timeoutCycles clock cycles.
 */

`ifndef TB_BRAM_SUBSYS_TASKS_SVH
`define TB_BRAM_SUBSYS_TASKS_SVH

// Compare of one host data word
task automatic checkWord(input mstWordT got, input mstWordT exp, input string what);
  if (got !== exp) begin
    $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    $display("Errors found");
    $fatal(1, "data word mismatch");
  end
endtask

// Compare of a single handshake bit
task automatic checkAck(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
    $display("Errors found");
    $fatal(1, "handshake bit mismatch");
  end
endtask

// One four-phase transaction, req held for hold extra cycles after ack
task automatic doAccess(input logic rs, input logic w, input addrT a, input mstWordT d,
                        input byteEnT be, input int hold, output mstWordT rd);
  int cnt;
  @(negedge FromMaster_PS);
  regSel = rs;
  we     = w;
  addr   = a;
  wrData = d;
  byteEn = be;
  req    = 1'b1;
  cnt    = 0;
  // Phase 2, wait for ack to rise
  while (ack !== 1'b1) begin
    @(negedge FromMaster_PS);
    cnt++;
    if (cnt > timeoutCycles) begin
      $display("Timeout: ack did not rise after req at address %h", a);
      $display("Errors found");
      $fatal(1, "handshake timeout");
    end
  end
  rd = rdData;
  // Back-pressure, ack and data must hold while req stays high
  for (int i = 0; i < hold; i++) begin
    @(negedge FromMaster_PS);
    checkAck(ack, 1'b1, "ack held while req high");
    checkWord(rdData, rd, "rdData held while req high");
  end
  req = 1'b0;
  cnt = 0;
  // Phase 4, wait for ack to fall
  while (ack !== 1'b0) begin
    @(negedge FromMaster_PS);
    cnt++;
    if (cnt > timeoutCycles) begin
      $display("Timeout: ack did not fall after req dropped at address %h", a);
      $display("Errors found");
      $fatal(1, "handshake timeout");
    end
  end
endtask

`endif

//--- tbBramSubsys.sv
/*
 * Testbench for the 32-bit host to 96-bit BRAM subsystem.
 * Directed table first, then a random phase with base 0 and protect clear.
 */

`timescale 1ns/1ns

module tbBramSubsys
  import bramDwcPkg::*;
();

  logic    FromMaster_PS = 1'b0;
  logic    rstN;
  logic    req;
  logic    we;
  logic    regSel;
  addrT    addr;
  mstWordT wrData;
  byteEnT  byteEn;
  logic    ack;
  mstWordT rdData;

  // Cycles allowed for each ack edge
  int timeoutCycles = 20;
  integer seed = 32'h312140d7;

  // One directed transaction and its expected read data
  typedef struct packed {
    logic    regSel;
    logic    we;
    addrT    addr;
    mstWordT wrData;
    byteEnT  byteEn;
    mstWordT expRd;
  } rowT;

  rowT rows[$];

  // Host word model, 768 words
  mstWordT     model [laneCount*slvDepth];
  logic [13:0] modelBase;
  logic        modelProtect;

  bramSubsysTop uut (
    .FromMaster_PS, .rstN, .req, .we, .regSel, .addr, .wrData, .byteEn,
    .ack, .rdData
  );

  // 8 ns period
  always #4 FromMaster_PS = ~FromMaster_PS;

  `include "tbBramSubsysTasks.svh"

  task automatic addRow(input logic rs, input logic w, input addrT a, input mstWordT d,
                        input byteEnT be, input mstWordT exp);
    rowT r;
    r.regSel = rs;
    r.we     = w;
    r.addr   = a;
    r.wrData = d;
    r.byteEn = be;
    r.expRd  = exp;
    rows.push_back(r);
  endtask

  // Distinct word per host address, all ten index bits show up
  function automatic mstWordT fillWord(input int w);
    logic [9:0] idx;
    idx = w[9:0];
    return {idx, 6'b101101, ~idx, 6'b010011};
  endfunction

  // Byte lanes of new data replace old ones where enabled
  function automatic mstWordT mergeBytes(input mstWordT old, input mstWordT d, input byteEnT be);
    mstWordT res;
    res = old;
    for (int b = 0; b < mstBytes; b++) begin
      if (be[b]) res[b*8 +: 8] = d[b*8 +: 8];
    end
    return res;
  endfunction

  // Relocated word, wraps at 2^14 and aliases onto 768 stored words
  function automatic int modelIndex(input int w);
    return ((w + modelBase) % 16384) % (laneCount * slvDepth);
  endfunction

  task automatic applyWrite(input int w, input mstWordT d, input byteEnT be);
    int idx;
    idx = modelIndex(w);
    if (!modelProtect) model[idx] = mergeBytes(model[idx], d, be);
  endtask

  initial begin
    mstWordT rd;
    int      w;
    logic    opWe;
    byteEnT  opBe;
    mstWordT opData;
    int      hold;

    rstN   = 1'b0;
    req    = 1'b0;
    we     = 1'b0;
    regSel = 1'b0;
    addr   = '0;
    wrData = '0;
    byteEn = '0;

    // Registers read zero after reset
    addRow(1, 0, 16'h0000, '0, '0, 32'h0);
    addRow(1, 0, 16'h0001, '0, '0, 32'h0);
    // Three lanes of BRAM word 0
    addRow(0, 1, 16'h0000, 32'h11111111, 4'hF, '0);
    addRow(0, 1, 16'h0004, 32'h22222222, 4'hF, '0);
    addRow(0, 1, 16'h0008, 32'h33333333, 4'hF, '0);
    addRow(0, 0, 16'h0000, '0, '0, 32'h11111111);
    addRow(0, 0, 16'h0004, '0, '0, 32'h22222222);
    addRow(0, 0, 16'h0008, '0, '0, 32'h33333333);
    // Partial write to the middle lane, bytes 0 and 2 only
    addRow(0, 1, 16'h0004, 32'hAABBCCDD, 4'b0101, '0);
    addRow(0, 0, 16'h0004, '0, '0, 32'h22BB22DD);
    addRow(0, 0, 16'h0000, '0, '0, 32'h11111111);
    addRow(0, 0, 16'h0008, '0, '0, 32'h33333333);
    // Word 13 written directly, then reached as word 3 with base 10
    addRow(0, 1, 16'h0034, 32'h5A5A0013, 4'hF, '0);
    addRow(1, 1, 16'h0000, 32'h0000000A, 4'hF, '0);
    addRow(1, 0, 16'h0000, '0, '0, 32'h0000000A);
    addRow(0, 0, 16'h000C, '0, '0, 32'h5A5A0013);
    // Word 4 with base 10 lands on word 14
    addRow(0, 1, 16'h0010, 32'h00000077, 4'hF, '0);
    addRow(1, 1, 16'h0000, 32'h0, 4'hF, '0);
    addRow(0, 0, 16'h0038, '0, '0, 32'h00000077);
    // Protected write is acked but leaves word 0 alone
    addRow(1, 1, 16'h0001, 32'h1, 4'hF, '0);
    addRow(1, 0, 16'h0001, '0, '0, 32'h1);
    addRow(0, 1, 16'h0000, 32'hDEADBEEF, 4'hF, '0);
    addRow(0, 0, 16'h0000, '0, '0, 32'h11111111);
    addRow(1, 1, 16'h0001, 32'h0, 4'hF, '0);
    addRow(0, 1, 16'h0000, 32'hDEADBEEF, 4'hF, '0);
    addRow(0, 0, 16'h0000, '0, '0, 32'hDEADBEEF);
    // Word 768 aliases word 0
    addRow(0, 0, 16'h0C00, '0, '0, 32'hDEADBEEF);

    repeat (4) @(posedge FromMaster_PS);
    @(negedge FromMaster_PS);
    rstN = 1'b1;
    @(negedge FromMaster_PS);
    checkAck(ack, 1'b0, "ack after reset");
    checkWord(rdData, '0, "rdData after reset");

    foreach (rows[i]) begin
      doAccess(rows[i].regSel, rows[i].we, rows[i].addr, rows[i].wrData,
               rows[i].byteEn, i % 3, rd);
      if (!rows[i].we) checkWord(rd, rows[i].expRd, $sformatf("table row %0d", i));
    end

    // Table leaves base 0 and protect clear
    modelBase    = '0;
    modelProtect = 1'b0;

    // Known contents for every host word before random traffic
    for (int f = 0; f < laneCount * slvDepth; f++) begin
      doAccess(1'b0, 1'b1, addrT'(f * 4), fillWord(f), 4'hF, 0, rd);
      applyWrite(f, fillWord(f), 4'hF);
    end

    for (int n = 0; n < 400; n++) begin
      w      = $unsigned($random(seed)) % (laneCount * slvDepth);
      opWe   = $random(seed);
      opBe   = $random(seed);
      opData = $random(seed);
      hold   = $unsigned($random(seed)) % 4;
      doAccess(1'b0, opWe, addrT'(w * 4), opData, opBe, hold, rd);
      if (opWe) begin
        applyWrite(w, opData, opBe);
      end else begin
        checkWord(rd, model[modelIndex(w)], $sformatf("random read of word %0d", w));
      end
    end

    $display("No errors");
    $finish;
  end

endmodule

//--- wideBram.sv
/*
 * Single-port 96-bit memory with byte enables and one cycle read latency.
 * Read during write returns the old word; array contents are not reset.
 */

`timescale 1ns/1ns

module wideBram
  import bramDwcPkg::*;
(
  input  logic                   FromMaster_PS,
  input  logic                   rstN,
  input  logic                   memEn,
  input  slvByteEnT              memWe,
  input  logic [slvAddrBits-1:0] memAddr,
  input  wideWordU               memWrData,
  output wideWordU               memRdData
);

  logic [slvDataBits-1:0] mem [slvDepth];

  // Byte-wise write
  always_ff @(posedge FromMaster_PS) begin
    if (memEn) begin
      for (int b = 0; b < slvBytes; b++) begin
        if (memWe[b]) begin
          mem[memAddr][b*8 +: 8] <= memWrData.flat[b*8 +: 8];
        end
      end
    end
  end

  // Output register, holds its value between enables
  always_ff @(posedge FromMaster_PS or negedge rstN) begin
    if (!rstN) begin
      memRdData.flat <= '0;
    end else if (memEn) begin
      memRdData.flat <= mem[memAddr];
    end
  end

  // Byte enables only come with a memory cycle
  weNeedsEn: assert property (@(posedge FromMaster_PS) disable iff (!rstN)
    (|memWe) |-> memEn);

endmodule

//--- windowRegs.sv
/*
 * Base and control registers for address relocation and write protect.
 * Writes are whole-word; unused register bits read back as zero.
 */

`timescale 1ns/1ns

module windowRegs
  import bramDwcPkg::*;
(
  input  logic        FromMaster_PS,
  input  logic        rstN,
  input  logic        regWrEn,
  input  logic        regAddrSel,
  input  mstWordT     regWrData,
  output mstWordT     regRdData,
  output logic [13:0] base,
  output logic        protect
);

  // Register select decode
  logic selBase;
  logic selCtrl;

  assign selBase = (regAddrSel == 1'(regBaseAddr));
  assign selCtrl = (regAddrSel == 1'(regCtrlAddr));

  // Word offset added to every memory access
  always_ff @(posedge FromMaster_PS or negedge rstN) begin
    if (!rstN) begin
      base <= '0;
    end else if (regWrEn && selBase) begin
      base <= regWrData[13:0];
    end
  end

  // Control register, bit 0 blocks memory writes
  always_ff @(posedge FromMaster_PS or negedge rstN) begin
    if (!rstN) begin
      protect <= 1'b0;
    end else if (regWrEn && selCtrl) begin
      protect <= regWrData[0];
    end
  end

  // Readback, zero-extended to the host word
  always_comb begin
    regRdData = '0;
    if (selCtrl) begin
      regRdData[0] = protect;
    end else begin
      regRdData[13:0] = base;
    end
  end

endmodule
